// ==== src/l2_macros.svh ====
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

// Cache geometry of 16 sets of eight 64-bit words
`define L2_SET_BITS 4
`define L2_WORD_BITS 3

// FIFO depths in entries
`define L2_INV_DEPTH 8
`define L2_RESP_DEPTH 4

// Bus id of the cache when not overridden
`define L2_BUSID 3'd1

`endif

// ==== src/l2_pkg.sv ====
`include "l2_macros.svh"

package l2_pkg;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLUSH = 2'd2,
    OP_RSVD  = 2'd3
  } op_t;

  typedef logic [31:3] word_addr_t;
  typedef logic [31:6] line_addr_t;

  // Fields of a word address
  typedef logic [31:6+`L2_SET_BITS] ctag_t;
  typedef logic [`L2_SET_BITS-1:0] set_t;
  typedef logic [`L2_WORD_BITS-1:0] widx_t;

  typedef logic [63:0] word_t;
  typedef logic [7:0] mask_t;

  typedef struct packed {
    logic  error;
    word_t rdata;
  } resp_t;

endpackage

// ==== src/bus_pkg.sv ====
package bus_pkg;

  typedef enum logic [2:0] {
    CMD_IDLE    = 3'd0,
    CMD_RD_LINE = 3'd1,
    CMD_WR_LINE = 3'd2,
    CMD_FILL    = 3'd3
  } cmd_t;

  typedef logic [2:0] busid_t;
  typedef logic [2:0] beat_t;

  // Requester id on top, beat index below
  typedef struct packed {
    busid_t id;
    beat_t  beat;
  } tag_t;

endpackage

// ==== src/l2_fifo.sv ====
module l2_fifo #(
  parameter type T = logic,
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n,
  input  logic wr_valid,
  output logic wr_ready,
  input  T     wr_data,
  output logic rd_valid,
  input  logic rd_ready,
  output T     rd_data,
  output logic empty
);

  localparam int AW = $clog2(DEPTH);

  T mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0] count;
  logic wr_en;
  logic rd_en;

  assign wr_ready = count != (AW+1)'(DEPTH);
  assign rd_valid = count != '0;
  assign empty = count == '0;
  assign wr_en = wr_valid && wr_ready;
  assign rd_en = rd_valid && rd_ready;

  // Oldest entry or zero while empty
  assign rd_data = rd_valid ? mem[rd_ptr] : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== src/l2tag.sv ====
`include "l2_macros.svh"

module l2tag (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req_valid,
  input  l2_pkg::op_t        req_op,
  input  l2_pkg::word_addr_t req_addr,
  input  l2_pkg::mask_t      req_wmask,
  input  l2_pkg::word_t      req_wdata,
  output logic               req_ready,
  output logic               acc_valid,
  output logic               acc_write,
  output l2_pkg::set_t       acc_set,
  output l2_pkg::widx_t      acc_word,
  output l2_pkg::mask_t      acc_wmask,
  output l2_pkg::word_t      acc_wdata,
  output logic               resp_push,
  output logic               resp_error,
  input  logic               resp_ready_in,
  output logic               inv_valid,
  output l2_pkg::line_addr_t inv_addr,
  input  logic               inv_ready,
  output logic               trans_start,
  output bus_pkg::cmd_t      trans_cmd,
  output l2_pkg::line_addr_t trans_addr,
  input  logic               trans_done,
  output logic               ctl_idle
);

  localparam int NSETS = 1 << `L2_SET_BITS;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FILL, ACCESS} state_t;

  state_t state;
  state_t state_nxt;
  logic started;
  l2_pkg::op_t op_q;
  l2_pkg::word_addr_t addr_q;
  l2_pkg::mask_t wmask_q;
  l2_pkg::word_t wdata_q;
  l2_pkg::ctag_t tag_mem [NSETS];
  logic [NSETS-1:0] valid_q;
  logic [NSETS-1:0] dirty_q;
  l2_pkg::ctag_t req_tag;
  l2_pkg::line_addr_t victim;
  logic hit;
  logic victim_dirty;

  assign req_tag = addr_q[31:6+`L2_SET_BITS];
  assign acc_set = addr_q[6 +: `L2_SET_BITS];
  assign acc_word = addr_q[3 +: `L2_WORD_BITS];
  assign acc_wmask = wmask_q;
  assign acc_wdata = wdata_q;
  assign acc_valid = state == ACCESS;
  assign acc_write = op_q == l2_pkg::OP_WRITE;

  assign hit = valid_q[acc_set] && tag_mem[acc_set] == req_tag;
  assign victim = {tag_mem[acc_set], acc_set};
  assign victim_dirty = valid_q[acc_set] && dirty_q[acc_set];

  // One request in flight and room in both FIFOs at acceptance
  assign req_ready = started && state == IDLE && resp_ready_in && inv_ready;
  assign ctl_idle = state == IDLE;

  always_comb begin
    state_nxt = state;
    resp_push = 1'b0;
    resp_error = 1'b0;
    inv_valid = 1'b0;
    inv_addr = victim;
    trans_start = 1'b0;
    trans_cmd = bus_pkg::CMD_RD_LINE;
    trans_addr = addr_q[31:6];
    case (state)
      IDLE: begin
        if (req_valid && req_ready) begin
          state_nxt = LOOKUP;
        end
      end
      LOOKUP: begin
        if (op_q == l2_pkg::OP_RSVD) begin
          resp_push = 1'b1;
          resp_error = 1'b1;
          state_nxt = IDLE;
        end else if (op_q == l2_pkg::OP_FLUSH && !hit) begin
          resp_push = 1'b1;
          state_nxt = IDLE;
        end else if (op_q == l2_pkg::OP_FLUSH) begin
          inv_valid = 1'b1;
          if (victim_dirty) begin
            trans_start = 1'b1;
            trans_cmd = bus_pkg::CMD_WR_LINE;
            trans_addr = victim;
            state_nxt = WRITEBACK;
          end else begin
            resp_push = 1'b1;
            state_nxt = IDLE;
          end
        end else if (hit) begin
          state_nxt = ACCESS;
        end else begin
          // Miss drops the old line, writes it back if needed, then refills
          inv_valid = valid_q[acc_set];
          trans_start = 1'b1;
          if (victim_dirty) begin
            trans_cmd = bus_pkg::CMD_WR_LINE;
            trans_addr = victim;
            state_nxt = WRITEBACK;
          end else begin
            state_nxt = FILL;
          end
        end
      end
      WRITEBACK: begin
        if (trans_done && op_q == l2_pkg::OP_FLUSH) begin
          resp_push = 1'b1;
          state_nxt = IDLE;
        end else if (trans_done) begin
          trans_start = 1'b1;
          state_nxt = FILL;
        end
      end
      FILL: begin
        if (trans_done) begin
          state_nxt = ACCESS;
        end
      end
      ACCESS: begin
        resp_push = 1'b1;
        state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      started <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state <= state_nxt;
      started <= 1'b1;
      if (inv_valid) begin
        valid_q[acc_set] <= 1'b0;
        dirty_q[acc_set] <= 1'b0;
      end
      if (state == FILL && trans_done) begin
        valid_q[acc_set] <= 1'b1;
      end
      if (acc_valid && acc_write) begin
        dirty_q[acc_set] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op_q <= req_op;
      addr_q <= req_addr;
      wmask_q <= req_wmask;
      wdata_q <= req_wdata;
    end
    if (state == FILL && trans_done) begin
      tag_mem[acc_set] <= req_tag;
    end
  end

endmodule

// ==== src/l2data.sv ====
`include "l2_macros.svh"

module l2data (
  input  logic          clk,
  input  logic          acc_valid,
  input  logic          acc_write,
  input  l2_pkg::set_t  acc_set,
  input  l2_pkg::widx_t acc_word,
  input  l2_pkg::mask_t acc_wmask,
  input  l2_pkg::word_t acc_wdata,
  input  logic          fill_valid,
  input  l2_pkg::widx_t fill_beat,
  input  l2_pkg::word_t fill_data,
  input  l2_pkg::widx_t wb_beat,
  output l2_pkg::word_t wb_data,
  output l2_pkg::word_t rdata_out
);

  localparam int NWORDS = 1 << (`L2_SET_BITS + `L2_WORD_BITS);

  l2_pkg::word_t mem [NWORDS];
  l2_pkg::word_t rd_q;

  // Request set and word stay fixed while a request is in flight
  always_ff @(posedge clk) begin
    if (acc_valid && acc_write) begin
      for (int b = 0; b < 8; b++) begin
        if (acc_wmask[b]) begin
          mem[{acc_set, acc_word}][8*b +: 8] <= acc_wdata[8*b +: 8];
        end
      end
    end
    if (fill_valid) begin
      mem[{acc_set, fill_beat}] <= fill_data;
    end
    rd_q <= mem[{acc_set, acc_word}];
    // Next writeback beat fetched a cycle early
    wb_data <= mem[{acc_set, wb_beat}];
  end

  // Writes and non-data responses return zero
  assign rdata_out = (acc_valid && !acc_write) ? rd_q : '0;

endmodule

// ==== src/l2trans.sv ====
`include "l2_macros.svh"

module l2trans #(
  parameter bus_pkg::busid_t BUS_ID = `L2_BUSID
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  bus_pkg::cmd_t      cmd,
  input  l2_pkg::line_addr_t line_addr,
  output logic               done,
  output bus_pkg::beat_t     wb_beat,
  input  l2_pkg::word_t      wb_data,
  output logic               fill_valid,
  output bus_pkg::beat_t     fill_beat,
  output l2_pkg::word_t      fill_data,
  output logic               bus_req,
  output bus_pkg::cmd_t      bus_cmd_out,
  output bus_pkg::tag_t      bus_tag_out,
  output l2_pkg::line_addr_t bus_addr_out,
  output l2_pkg::word_t      bus_data_out,
  input  logic               bus_grant,
  input  logic               bus_valid,
  input  bus_pkg::cmd_t      bus_cmd,
  input  bus_pkg::tag_t      bus_tag,
  input  l2_pkg::line_addr_t bus_addr,
  input  l2_pkg::word_t      bus_data
);

  logic busy;
  logic wr_grant;
  logic last;
  bus_pkg::cmd_t cmd_q;
  l2_pkg::line_addr_t addr_q;
  bus_pkg::beat_t beat_q;

  assign wr_grant = bus_req && bus_grant && cmd_q == bus_pkg::CMD_WR_LINE;
  assign last = beat_q == '1;

  // Own fill beats for the outstanding line only
  assign fill_valid = busy && !bus_req && cmd_q == bus_pkg::CMD_RD_LINE && bus_valid &&
                      bus_cmd == bus_pkg::CMD_FILL && bus_tag.id == BUS_ID &&
                      bus_addr == addr_q;
  assign fill_beat = bus_tag.beat;
  assign fill_data = bus_data;

  assign wb_beat = start ? '0 : (wr_grant ? beat_q + 1'b1 : beat_q);

  assign bus_cmd_out = bus_req ? cmd_q : bus_pkg::CMD_IDLE;
  assign bus_tag_out = '{id: BUS_ID, beat: beat_q};
  assign bus_addr_out = addr_q;
  assign bus_data_out = (bus_req && cmd_q == bus_pkg::CMD_WR_LINE) ? wb_data : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      bus_req <= 1'b0;
      done <= 1'b0;
      cmd_q <= bus_pkg::CMD_IDLE;
      addr_q <= '0;
      beat_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        bus_req <= 1'b1;
        cmd_q <= cmd;
        addr_q <= line_addr;
        beat_q <= '0;
      end else if (wr_grant) begin
        if (last) begin
          bus_req <= 1'b0;
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end else if (bus_req && bus_grant) begin
        // Fills follow a granted line read
        bus_req <= 1'b0;
      end else if (fill_valid) begin
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/l2.sv ====
`include "l2_macros.svh"

module l2 #(
  parameter bus_pkg::busid_t BUS_ID = `L2_BUSID
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req_valid,
  input  l2_pkg::op_t        req_op,
  input  l2_pkg::word_addr_t req_addr,
  input  l2_pkg::mask_t      req_wmask,
  input  l2_pkg::word_t      req_wdata,
  output logic               req_ready,
  output logic               resp_valid,
  output logic               resp_error,
  output l2_pkg::word_t      resp_rdata,
  input  logic               resp_ready,
  output logic               inv_valid,
  output l2_pkg::line_addr_t inv_addr,
  input  logic               inv_ready,
  output logic               idle,
  output logic               bus_req,
  output bus_pkg::cmd_t      bus_cmd_out,
  output bus_pkg::tag_t      bus_tag_out,
  output l2_pkg::line_addr_t bus_addr_out,
  output l2_pkg::word_t      bus_data_out,
  input  logic               bus_grant,
  input  logic               bus_valid,
  input  bus_pkg::cmd_t      bus_cmd,
  input  bus_pkg::tag_t      bus_tag,
  input  l2_pkg::line_addr_t bus_addr,
  input  l2_pkg::word_t      bus_data
);

  logic acc_valid;
  logic acc_write;
  l2_pkg::set_t acc_set;
  l2_pkg::widx_t acc_word;
  l2_pkg::mask_t acc_wmask;
  l2_pkg::word_t acc_wdata;
  logic fill_valid;
  bus_pkg::beat_t fill_beat;
  l2_pkg::word_t fill_data;
  bus_pkg::beat_t wb_beat;
  l2_pkg::word_t wb_data;
  l2_pkg::word_t rdata;
  logic resp_push;
  logic tag_resp_error;
  logic respfifo_ready;
  logic respfifo_empty;
  l2_pkg::resp_t resp_in;
  l2_pkg::resp_t resp_out;
  logic tag_inv_valid;
  l2_pkg::line_addr_t tag_inv_addr;
  logic invfifo_ready;
  logic invfifo_empty;
  logic trans_start;
  bus_pkg::cmd_t trans_cmd;
  l2_pkg::line_addr_t trans_addr;
  logic trans_done;
  logic ctl_idle;

  assign resp_in = '{error: tag_resp_error, rdata: rdata};
  assign resp_error = resp_out.error;
  assign resp_rdata = resp_out.rdata;
  assign idle = ctl_idle && invfifo_empty && respfifo_empty;

  l2tag l2tag (
    .clk, .arst_n,
    .req_valid, .req_op, .req_addr, .req_wmask, .req_wdata, .req_ready,
    .acc_valid, .acc_write, .acc_set, .acc_word, .acc_wmask, .acc_wdata,
    .resp_push, .resp_error(tag_resp_error), .resp_ready_in(respfifo_ready),
    .inv_valid(tag_inv_valid), .inv_addr(tag_inv_addr), .inv_ready(invfifo_ready),
    .trans_start, .trans_cmd, .trans_addr, .trans_done, .ctl_idle
  );

  l2data l2data (
    .clk,
    .acc_valid, .acc_write, .acc_set, .acc_word, .acc_wmask, .acc_wdata,
    .fill_valid, .fill_beat, .fill_data,
    .wb_beat, .wb_data, .rdata_out(rdata)
  );

  l2trans #(.BUS_ID(BUS_ID)) l2trans (
    .clk, .arst_n,
    .start(trans_start), .cmd(trans_cmd), .line_addr(trans_addr), .done(trans_done),
    .wb_beat, .wb_data, .fill_valid, .fill_beat, .fill_data,
    .bus_req, .bus_cmd_out, .bus_tag_out, .bus_addr_out, .bus_data_out, .bus_grant,
    .bus_valid, .bus_cmd, .bus_tag, .bus_addr, .bus_data
  );

  l2_fifo #(.T(l2_pkg::line_addr_t), .DEPTH(`L2_INV_DEPTH)) invfifo (
    .clk, .arst_n,
    .wr_valid(tag_inv_valid), .wr_ready(invfifo_ready), .wr_data(tag_inv_addr),
    .rd_valid(inv_valid), .rd_ready(inv_ready), .rd_data(inv_addr),
    .empty(invfifo_empty)
  );

  l2_fifo #(.T(l2_pkg::resp_t), .DEPTH(`L2_RESP_DEPTH)) respfifo (
    .clk, .arst_n,
    .wr_valid(resp_push), .wr_ready(respfifo_ready), .wr_data(resp_in),
    .rd_valid(resp_valid), .rd_ready(resp_ready), .rd_data(resp_out),
    .empty(respfifo_empty)
  );

endmodule

// ==== testbench/l2_assertions.sv ====
module l2_assertions (
  input logic               clk,
  input logic               arst_n,
  input logic               req_ready,
  input logic               resp_valid,
  input logic               resp_ready,
  input logic               resp_error,
  input l2_pkg::word_t      resp_rdata,
  input logic               inv_valid,
  input logic               inv_ready,
  input l2_pkg::line_addr_t inv_addr,
  input logic               idle,
  input logic               bus_req,
  input logic               bus_grant,
  input bus_pkg::cmd_t      bus_cmd_out,
  input bus_pkg::tag_t      bus_tag_out,
  input l2_pkg::line_addr_t bus_addr_out,
  input l2_pkg::word_t      bus_data_out
);
  timeunit 1ns;
  timeprecision 1ps;

  int req_fails = 0;
  int x_fails = 0;
  int hold_fails = 0;

  // Bus request holds command and address until granted
  assert property (@(posedge clk) disable iff (!arst_n)
    bus_req && !bus_grant |=> bus_req && $stable(bus_cmd_out) && $stable(bus_addr_out))
  else begin
    $error("bus_req dropped or changed before a grant");
    req_fails++;
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown({req_ready, resp_valid, resp_error, resp_rdata, inv_valid, inv_addr, idle,
                 bus_req, bus_cmd_out, bus_tag_out, bus_addr_out, bus_data_out}))
  else begin
    $error("unknown value on an l2 output");
    x_fails++;
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_error))
  else begin
    $error("response withdrawn before resp_ready");
    hold_fails++;
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    inv_valid && !inv_ready |=> inv_valid && $stable(inv_addr))
  else begin
    $error("invalidation withdrawn before inv_ready");
    hold_fails++;
  end

endmodule

bind l2 l2_assertions protocol (.*);

// ==== testbench/l2_tb.sv ====
`include "l2_macros.svh"

module l2_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 21;
  localparam int LIMIT = NROWS * 60 + 100;

  typedef struct packed {
    l2_pkg::op_t   op;
    logic [31:0]   baddr;
    l2_pkg::mask_t mask;
    l2_pkg::word_t data;
    logic          stall;
    logic [3:0]    bus;
  } row_t;

  // Op, byte address, mask, write data, random back-pressure, expected bus grants
  localparam row_t ROWS [NROWS] = '{
    '{l2_pkg::OP_READ,  32'h0000_1040, 8'h00, 64'h0, 1'b0, 4'd1},
    '{l2_pkg::OP_READ,  32'h0000_1058, 8'h00, 64'h0, 1'b0, 4'd0},
    '{l2_pkg::OP_WRITE, 32'h0000_1048, 8'h0f, 64'h1111_2222_3333_4444, 1'b0, 4'd0},
    '{l2_pkg::OP_WRITE, 32'h0000_1048, 8'hf0, 64'haaaa_bbbb_cccc_dddd, 1'b0, 4'd0},
    '{l2_pkg::OP_READ,  32'h0000_1048, 8'h00, 64'h0, 1'b0, 4'd0},
    '{l2_pkg::OP_READ,  32'h0000_2040, 8'h00, 64'h0, 1'b0, 4'd9},
    '{l2_pkg::OP_READ,  32'h0000_1048, 8'h00, 64'h0, 1'b0, 4'd1},
    '{l2_pkg::OP_WRITE, 32'h0000_30c0, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0, 4'd1},
    '{l2_pkg::OP_FLUSH, 32'h0000_30c0, 8'h00, 64'h0, 1'b0, 4'd8},
    '{l2_pkg::OP_FLUSH, 32'h0000_30c0, 8'h00, 64'h0, 1'b0, 4'd0},
    '{l2_pkg::OP_FLUSH, 32'h0000_5000, 8'h00, 64'h0, 1'b0, 4'd0},
    '{l2_pkg::OP_RSVD,  32'h0000_1040, 8'h00, 64'h0, 1'b0, 4'd0},
    '{l2_pkg::OP_READ,  32'h0000_30c0, 8'h00, 64'h0, 1'b0, 4'd1},
    '{l2_pkg::OP_WRITE, 32'h0000_3140, 8'h3c, 64'h5566_7788_99aa_bbcc, 1'b1, 4'd1},
    '{l2_pkg::OP_READ,  32'h0000_5140, 8'h00, 64'h0, 1'b1, 4'd9},
    '{l2_pkg::OP_READ,  32'h0000_3140, 8'h00, 64'h0, 1'b1, 4'd1},
    '{l2_pkg::OP_WRITE, 32'h0000_1040, 8'h81, 64'hfeed_0000_0000_beef, 1'b1, 4'd0},
    '{l2_pkg::OP_READ,  32'h0000_2078, 8'h00, 64'h0, 1'b1, 4'd9},
    '{l2_pkg::OP_RSVD,  32'h0000_0000, 8'h00, 64'h0, 1'b1, 4'd0},
    '{l2_pkg::OP_FLUSH, 32'h0000_2078, 8'h00, 64'h0, 1'b1, 4'd0},
    '{l2_pkg::OP_READ,  32'h0000_1040, 8'h00, 64'h0, 1'b1, 4'd1}
  };

  logic clk;
  logic arst_n;
  logic req_valid;
  l2_pkg::op_t req_op;
  l2_pkg::word_addr_t req_addr;
  l2_pkg::mask_t req_wmask;
  l2_pkg::word_t req_wdata;
  logic req_ready;
  logic resp_valid;
  logic resp_error;
  l2_pkg::word_t resp_rdata;
  logic resp_ready = 1'b1;
  logic inv_valid;
  l2_pkg::line_addr_t inv_addr;
  logic inv_ready = 1'b1;
  logic idle;
  logic bus_req;
  bus_pkg::cmd_t bus_cmd_out;
  bus_pkg::tag_t bus_tag_out;
  l2_pkg::line_addr_t bus_addr_out;
  l2_pkg::word_t bus_data_out;
  logic bus_grant = 1'b0;
  logic bus_valid = 1'b0;
  bus_pkg::cmd_t bus_cmd = bus_pkg::CMD_IDLE;
  bus_pkg::tag_t bus_tag = '0;
  l2_pkg::line_addr_t bus_addr = '0;
  l2_pkg::word_t bus_data = '0;

  // Program-order memory, bus memory and the expected cache contents
  l2_pkg::word_t ref_mem [l2_pkg::word_addr_t];
  l2_pkg::word_t bus_mem [l2_pkg::word_addr_t];
  logic [21:0] ref_tag [16];
  logic [15:0] ref_valid = '0;
  l2_pkg::line_addr_t exp_inv [$];
  l2_pkg::resp_t resp_got [$];

  int cycle = 0;
  int errors = 0;
  int grants = 0;
  bit stall = 1'b0;
  int grant_wait = 0;
  bit fill_on = 1'b0;
  int fill_wait = 0;
  int fill_idx = 0;
  l2_pkg::line_addr_t fill_line;
  int resp_rise = 0;
  bit resp_seen = 1'b0;

  l2 dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic l2_pkg::word_t init_word(l2_pkg::word_addr_t a);
    return {3'b101, a, 3'b011, a ^ 29'h0f0f_0f0f};
  endfunction

  function automatic l2_pkg::word_t ref_read(l2_pkg::word_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
  endfunction

  function automatic l2_pkg::word_t bus_read(l2_pkg::word_addr_t a);
    return bus_mem.exists(a) ? bus_mem[a] : init_word(a);
  endfunction

  function automatic l2_pkg::word_t merge(l2_pkg::word_t old, l2_pkg::word_t wdata,
                                          l2_pkg::mask_t m);
    l2_pkg::word_t w;
    w = old;
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        w[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_word(input string what, input l2_pkg::word_t got,
                            input l2_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_line(input string what, input l2_pkg::line_addr_t got,
                            input l2_pkg::line_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got line %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_error(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_busid(input string what, input bus_pkg::busid_t got,
                             input bus_pkg::busid_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("error %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Direct-mapped cache model updated as each request is issued
  task automatic predict(input row_t r, output l2_pkg::resp_t exp, output bit hit);
    l2_pkg::word_addr_t a;
    logic [3:0] s;
    a = r.baddr[31:3];
    s = r.baddr[9:6];
    hit = ref_valid[s] && ref_tag[s] == r.baddr[31:10];
    exp = '0;
    if (r.op == l2_pkg::OP_RSVD) begin
      exp.error = 1'b1;
    end else if (r.op == l2_pkg::OP_FLUSH) begin
      if (hit) begin
        exp_inv.push_back(r.baddr[31:6]);
        ref_valid[s] = 1'b0;
      end
    end else begin
      if (!hit && ref_valid[s]) begin
        exp_inv.push_back({ref_tag[s], s});
      end
      ref_valid[s] = 1'b1;
      ref_tag[s] = r.baddr[31:10];
      if (r.op == l2_pkg::OP_WRITE) begin
        ref_mem[a] = merge(ref_read(a), r.data, r.mask);
      end else begin
        exp.rdata = ref_read(a);
      end
    end
  endtask

  // Bus and port model whose values transfer at the next rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      resp_ready = stall ? 1'($urandom_range(0, 1)) : 1'b1;
      inv_ready = stall ? 1'($urandom_range(0, 1)) : 1'b1;
      if (resp_valid && !resp_seen) begin
        resp_rise = cycle;
        resp_seen = 1'b1;
      end
      if (resp_valid && resp_ready) begin
        resp_got.push_back('{error: resp_error, rdata: resp_rdata});
        resp_seen = 1'b0;
      end
      if (inv_valid && inv_ready) begin
        if (exp_inv.size() == 0) begin
          errors++;
          $display("unexpected invalidation of line %h at %0t", inv_addr, $time);
        end else begin
          check_line("invalidation", inv_addr, exp_inv.pop_front());
        end
      end
      bus_valid = 1'b0;
      bus_cmd = bus_pkg::CMD_IDLE;
      if (fill_on) begin
        if (fill_wait > 0) begin
          fill_wait--;
        end else begin
          bus_valid = 1'b1;
          bus_cmd = bus_pkg::CMD_FILL;
          bus_tag = '{id: `L2_BUSID, beat: 3'(fill_idx)};
          bus_addr = fill_line;
          bus_data = bus_read({fill_line, 3'(fill_idx)});
          fill_idx++;
          fill_on = fill_idx < 8;
        end
      end
      bus_grant = 1'b0;
      if (bus_req) begin
        if (grant_wait > 0) begin
          grant_wait--;
        end else begin
          bus_grant = 1'b1;
          grants++;
          grant_wait = $urandom_range(0, 3);
          check_busid("bus tag id", bus_tag_out.id, `L2_BUSID);
          if (bus_cmd_out == bus_pkg::CMD_WR_LINE) begin
            bus_mem[{bus_addr_out, bus_tag_out.beat}] = bus_data_out;
          end else if (bus_cmd_out == bus_pkg::CMD_RD_LINE) begin
            fill_on = 1'b1;
            fill_wait = $urandom_range(2, 5);
            fill_idx = 0;
            fill_line = bus_addr_out;
          end else begin
            errors++;
            $display("bus request with unexpected command %s at %0t",
                     bus_cmd_out.name(), $time);
          end
        end
      end
    end
  end

  initial begin
    row_t r;
    l2_pkg::op_t op;
    l2_pkg::resp_t exp;
    l2_pkg::resp_t got;
    bit hit;
    int acc;
    int g0;
    int e0;
    int afails;
    void'($urandom(32'h6f5d_139f));
    arst_n = 1'b0;
    req_valid = 1'b0;
    req_op = l2_pkg::OP_READ;
    req_addr = '0;
    req_wmask = '0;
    req_wdata = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < NROWS; i++) begin
      r = ROWS[i];
      op = r.op;
      e0 = errors;
      g0 = grants;
      stall = r.stall;
      predict(r, exp, hit);
      req_valid = 1'b1;
      req_op = r.op;
      req_addr = r.baddr[31:3];
      req_wmask = r.mask;
      req_wdata = r.data;
      while (!req_ready) @(negedge clk);
      acc = cycle + 1;
      @(negedge clk);
      req_valid = 1'b0;
      while (resp_got.size() == 0) @(negedge clk);
      got = resp_got.pop_front();
      check_error("response error", got.error, exp.error);
      check_word("response data", got.rdata, exp.rdata);
      check_count("bus grants", grants - g0, int'(r.bus));
      if (hit && !r.stall && (op == l2_pkg::OP_READ || op == l2_pkg::OP_WRITE)) begin
        check_count("hit latency", resp_rise - acc, 2);
      end
      $display("test %0d %s at %h: %s", i, op.name(), r.baddr, errors == e0 ? "ok" : "FAILED");
    end
    stall = 1'b0;
    while (!(idle && exp_inv.size() == 0)) @(negedge clk);
    check_count("responses left over", resp_got.size(), 0);
    afails = dut.protocol.req_fails + dut.protocol.x_fails + dut.protocol.hold_fails;
    $display("%0d tests, %0d errors, %0d assertion failures", NROWS, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/l2_pkg.sv
src/bus_pkg.sv
src/l2_fifo.sv
src/l2tag.sv
src/l2data.sv
src/l2trans.sv
src/l2.sv
testbench/l2_assertions.sv
testbench/l2_tb.sv

// ==== Makefile ====
TOP = l2_tb

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o l2_sim
	./obj_dir/l2_sim +verilator+error+limit+100 > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean
